/* include/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// storage sizes
`define CPU_XLEN        32
`define IMEM_WORDS      64
`define DMEM_WORDS      32

// loader framing bytes
`define LOAD_START_BYTE 8'hFE
`define LOAD_END_BYTE   8'hFF

// opcodes of the supported subset
`define OP_RTYPE        7'b0110011
`define OP_ITYPE        7'b0010011
`define OP_LOAD         7'b0000011
`define OP_STORE        7'b0100011

// {funct7, funct3} of the r-type ops
`define FUNCT_ADD       10'b0000000_000
`define FUNCT_SUB       10'b0100000_000
`define FUNCT_AND       10'b0000000_111
`define FUNCT_OR        10'b0000000_110

`endif

/* rtl/cpu_pkg.sv */
`include "cpu_settings.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0]             word_t;       // data or instruction word
    typedef logic [4:0]                       reg_addr_t;   // x0..x31
    typedef logic [$clog2(`IMEM_WORDS)-1:0]   imem_addr_t;  // instruction word index
    typedef logic [$clog2(`DMEM_WORDS)-1:0]   dmem_addr_t;  // data word index
    typedef logic [7:0]                       byte_t;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_NONE,    // value from ID/EX
        FWD_EX_MEM,  // previous instruction
        FWD_MEM_WB   // two instructions back
    } fwd_sel_e;

    typedef enum logic [1:0] {
        LOAD_IDLE,
        LOAD_BYTES,
        LOAD_RUN
    } loader_state_e;

endpackage

/* rtl/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top (
    input  logic               clk_i,
    input  logic               reset,
    input  cpu_pkg::byte_t     instr_i,
    input  logic               data_or_reg_i,  // 1 reads regs, 0 reads dmem
    input  cpu_pkg::reg_addr_t address_i,
    input  logic [1:0]         byte_sel_i,
    output cpu_pkg::byte_t     value_o
);
    import cpu_pkg::*;

    logic      run;  // high once the program is loaded
    word_t     if_instr;
    reg_addr_t rs1_addr, rs2_addr;
    word_t     rs1_data, rs2_data;
    reg_addr_t ex_rs1_addr, ex_rs2_addr, ex_rd_addr;
    word_t     ex_rs1_data, ex_rs2_data, ex_imm;
    alu_op_e   ex_alu_op;
    logic      ex_alu_src_imm, ex_reg_write, ex_mem_read, ex_mem_write;
    word_t     mem_alu_result, mem_store_data;
    reg_addr_t mem_rd_addr;
    logic      mem_reg_write, mem_mem_read, mem_mem_write;
    reg_addr_t wb_addr;
    word_t     wb_data;
    logic      wb_write;
    word_t     reg_read_data, mem_read_data, readout_word;

    instr_fetch fetch_i (
        .clk_i, .reset, .instr_i, .run_o(run), .if_instr_o(if_instr)
    );

    decode_stage decode_i (
        .clk_i, .reset, .if_instr_i(if_instr),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .ex_rs1_addr_o(ex_rs1_addr), .ex_rs2_addr_o(ex_rs2_addr), .ex_rd_addr_o(ex_rd_addr),
        .ex_rs1_data_o(ex_rs1_data), .ex_rs2_data_o(ex_rs2_data), .ex_imm_o(ex_imm),
        .ex_alu_op_o(ex_alu_op), .ex_alu_src_imm_o(ex_alu_src_imm),
        .ex_reg_write_o(ex_reg_write), .ex_mem_read_o(ex_mem_read),
        .ex_mem_write_o(ex_mem_write)
    );

    register_file regfile_i (
        .clk_i, .reset, .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
        .wb_addr_i(wb_addr), .read_addr_i(address_i), .wb_data_i(wb_data),
        .wb_write_i(wb_write), .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
        .read_data_o(reg_read_data)
    );

    execute_stage execute_i (
        .clk_i, .reset,
        .ex_rs1_addr_i(ex_rs1_addr), .ex_rs2_addr_i(ex_rs2_addr), .ex_rd_addr_i(ex_rd_addr),
        .ex_rs1_data_i(ex_rs1_data), .ex_rs2_data_i(ex_rs2_data), .ex_imm_i(ex_imm),
        .ex_alu_op_i(ex_alu_op), .ex_alu_src_imm_i(ex_alu_src_imm),
        .ex_reg_write_i(ex_reg_write), .ex_mem_read_i(ex_mem_read),
        .ex_mem_write_i(ex_mem_write),
        .wb_addr_i(wb_addr), .wb_data_i(wb_data), .wb_write_i(wb_write),
        .mem_alu_result_o(mem_alu_result), .mem_store_data_o(mem_store_data),
        .mem_rd_addr_o(mem_rd_addr), .mem_reg_write_o(mem_reg_write),
        .mem_mem_read_o(mem_mem_read), .mem_mem_write_o(mem_mem_write)
    );

    memory_stage memory_i (
        .clk_i, .reset, .mem_alu_result_i(mem_alu_result),
        .mem_store_data_i(mem_store_data), .mem_rd_addr_i(mem_rd_addr),
        .mem_reg_write_i(mem_reg_write), .mem_mem_read_i(mem_mem_read),
        .mem_mem_write_i(mem_mem_write), .read_addr_i(address_i),
        .wb_addr_o(wb_addr), .wb_data_o(wb_data), .wb_write_o(wb_write),
        .read_data_o(mem_read_data)
    );

    assign readout_word = data_or_reg_i ? reg_read_data : mem_read_data;
    assign value_o      = readout_word[{byte_sel_i, 3'b000} +: 8];  // 0 is bits 7:0

endmodule

/* rtl/decode_stage.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module decode_stage (
    input  logic               clk_i,
    input  logic               reset,
    input  cpu_pkg::word_t     if_instr_i,
    input  cpu_pkg::word_t     rs1_data_i,
    input  cpu_pkg::word_t     rs2_data_i,
    output cpu_pkg::reg_addr_t rs1_addr_o,
    output cpu_pkg::reg_addr_t rs2_addr_o,
    output cpu_pkg::reg_addr_t ex_rs1_addr_o,
    output cpu_pkg::reg_addr_t ex_rs2_addr_o,
    output cpu_pkg::reg_addr_t ex_rd_addr_o,
    output cpu_pkg::word_t     ex_rs1_data_o,
    output cpu_pkg::word_t     ex_rs2_data_o,
    output cpu_pkg::word_t     ex_imm_o,
    output cpu_pkg::alu_op_e   ex_alu_op_o,
    output logic               ex_alu_src_imm_o,
    output logic               ex_reg_write_o,
    output logic               ex_mem_read_o,
    output logic               ex_mem_write_o
);
    import cpu_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [9:0] funct;
    alu_op_e    alu_op;
    logic       alu_src_imm;
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    word_t      imm;

    assign opcode     = if_instr_i[6:0];
    assign funct3     = if_instr_i[14:12];
    assign funct      = {if_instr_i[31:25], funct3};
    assign rs1_addr_o = if_instr_i[19:15];
    assign rs2_addr_o = if_instr_i[24:20];

    always_comb begin
        alu_op      = ALU_ADD;  // address calc for lw/sw too
        alu_src_imm = 1'b0;
        reg_write   = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        case (opcode)
            `OP_RTYPE: begin
                reg_write = 1'b1;
                case (funct)
                    `FUNCT_ADD: alu_op = ALU_ADD;
                    `FUNCT_SUB: alu_op = ALU_SUB;
                    `FUNCT_AND: alu_op = ALU_AND;
                    `FUNCT_OR:  alu_op = ALU_OR;
                    default:    reg_write = 1'b0;  // other r-type ops are no-ops
                endcase
            end
            `OP_ITYPE: begin
                alu_src_imm = 1'b1;
                reg_write   = (funct3 == 3'b000);  // addi only
            end
            `OP_LOAD: begin
                alu_src_imm = 1'b1;
                reg_write   = (funct3 == 3'b010);  // lw only
                mem_read    = (funct3 == 3'b010);
            end
            `OP_STORE: begin
                alu_src_imm = 1'b1;
                mem_write   = (funct3 == 3'b010);  // sw only
            end
            default: reg_write = 1'b0;  // includes the all-zero word
        endcase
    end

    // s-type splits the immediate around rd
    assign imm = (opcode == `OP_STORE)
        ? {{(`CPU_XLEN-12){if_instr_i[31]}}, if_instr_i[31:25], if_instr_i[11:7]}
        : {{(`CPU_XLEN-12){if_instr_i[31]}}, if_instr_i[31:20]};

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            ex_alu_op_o      <= ALU_ADD;
            ex_alu_src_imm_o <= 1'b0;
            ex_reg_write_o   <= 1'b0;
            ex_mem_read_o    <= 1'b0;
            ex_mem_write_o   <= 1'b0;
        end else begin
            ex_alu_op_o      <= alu_op;
            ex_alu_src_imm_o <= alu_src_imm;
            ex_reg_write_o   <= reg_write;
            ex_mem_read_o    <= mem_read;
            ex_mem_write_o   <= mem_write;
        end
    end

    always_ff @(posedge clk_i) begin
        ex_rs1_addr_o <= rs1_addr_o;
        ex_rs2_addr_o <= rs2_addr_o;
        ex_rd_addr_o  <= if_instr_i[11:7];
        ex_rs1_data_o <= rs1_data_i;
        ex_rs2_data_o <= rs2_data_i;
        ex_imm_o      <= imm;
    end

endmodule

/* rtl/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic               clk_i,
    input  logic               reset,
    input  cpu_pkg::reg_addr_t ex_rs1_addr_i,
    input  cpu_pkg::reg_addr_t ex_rs2_addr_i,
    input  cpu_pkg::reg_addr_t ex_rd_addr_i,
    input  cpu_pkg::word_t     ex_rs1_data_i,
    input  cpu_pkg::word_t     ex_rs2_data_i,
    input  cpu_pkg::word_t     ex_imm_i,
    input  cpu_pkg::alu_op_e   ex_alu_op_i,
    input  logic               ex_alu_src_imm_i,
    input  logic               ex_reg_write_i,
    input  logic               ex_mem_read_i,
    input  logic               ex_mem_write_i,
    input  cpu_pkg::reg_addr_t wb_addr_i,
    input  cpu_pkg::word_t     wb_data_i,
    input  logic               wb_write_i,
    output cpu_pkg::word_t     mem_alu_result_o,
    output cpu_pkg::word_t     mem_store_data_o,
    output cpu_pkg::reg_addr_t mem_rd_addr_o,
    output logic               mem_reg_write_o,
    output logic               mem_mem_read_o,
    output logic               mem_mem_write_o
);
    import cpu_pkg::*;

    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;
    word_t    op_a;
    word_t    rs2_val;  // forwarded rs2, also the store data
    word_t    op_b;
    word_t    alu_result;

    // newest producer wins, so EX/MEM is checked before MEM/WB
    function automatic fwd_sel_e pick_fwd(input reg_addr_t rs);
        if (mem_reg_write_o && mem_rd_addr_o != '0 && mem_rd_addr_o == rs) begin
            return FWD_EX_MEM;
        end else if (wb_write_i && wb_addr_i != '0 && wb_addr_i == rs) begin
            return FWD_MEM_WB;
        end
        return FWD_NONE;
    endfunction

    function automatic word_t fwd_value(input fwd_sel_e sel, input word_t reg_val);
        case (sel)
            FWD_EX_MEM: return mem_alu_result_o;
            FWD_MEM_WB: return wb_data_i;
            default:    return reg_val;
        endcase
    endfunction

    always_comb begin
        fwd_a   = pick_fwd(ex_rs1_addr_i);
        fwd_b   = pick_fwd(ex_rs2_addr_i);
        op_a    = fwd_value(fwd_a, ex_rs1_data_i);
        rs2_val = fwd_value(fwd_b, ex_rs2_data_i);
        op_b    = ex_alu_src_imm_i ? ex_imm_i : rs2_val;
        case (ex_alu_op_i)
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            default: alu_result = op_a + op_b;
        endcase
    end

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            mem_reg_write_o <= 1'b0;
            mem_mem_read_o  <= 1'b0;
            mem_mem_write_o <= 1'b0;
        end else begin
            mem_reg_write_o <= ex_reg_write_i;
            mem_mem_read_o  <= ex_mem_read_i;
            mem_mem_write_o <= ex_mem_write_i;
        end
    end

    always_ff @(posedge clk_i) begin
        mem_alu_result_o <= alu_result;
        mem_store_data_o <= rs2_val;
        mem_rd_addr_o    <= ex_rd_addr_i;
    end

endmodule

/* rtl/instr_fetch.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module instr_fetch (
    input  logic           clk_i,
    input  logic           reset,
    input  cpu_pkg::byte_t instr_i,
    output logic           run_o,
    output cpu_pkg::word_t if_instr_o
);
    import cpu_pkg::*;

    loader_state_e                 state;
    logic [$bits(imem_addr_t)+1:0] byte_cnt;  // next byte position in imem
    imem_addr_t                    wr_word;
    logic [1:0]                    wr_lane;
    imem_addr_t                    pc;        // word index, not byte address
    word_t                         imem [`IMEM_WORDS];

    assign {wr_word, wr_lane} = byte_cnt;

    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            state    <= LOAD_IDLE;
            byte_cnt <= '0;
            run_o    <= 1'b0;
        end else begin
            run_o <= (state == LOAD_RUN);  // one edge after the end byte
            case (state)
                LOAD_IDLE: begin
                    if (instr_i == `LOAD_START_BYTE) begin
                        state <= LOAD_BYTES;
                    end
                end
                LOAD_BYTES: begin
                    if (instr_i == `LOAD_END_BYTE) begin
                        state <= LOAD_RUN;
                    end else begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                end
                default: state <= LOAD_RUN;  // held until reset
            endcase
        end
    end

    // one byte per clock, low byte of each word first
    always_ff @(posedge clk_i) begin
        if (state == LOAD_BYTES && instr_i != `LOAD_END_BYTE) begin
            imem[wr_word][{wr_lane, 3'b000} +: 8] <= instr_i;
        end
    end

    // pc and IF/ID, frozen at zero until the program is loaded
    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            pc         <= '0;
            if_instr_o <= '0;
        end else if (run_o) begin
            if_instr_o <= imem[pc];
            pc         <= pc + 1'b1;
        end
    end

endmodule

/* rtl/memory_stage.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module memory_stage (
    input  logic                clk_i,
    input  logic                reset,
    input  cpu_pkg::word_t      mem_alu_result_i,
    input  cpu_pkg::word_t      mem_store_data_i,
    input  cpu_pkg::reg_addr_t  mem_rd_addr_i,
    input  logic                mem_reg_write_i,
    input  logic                mem_mem_read_i,
    input  logic                mem_mem_write_i,
    input  cpu_pkg::dmem_addr_t read_addr_i,
    output cpu_pkg::reg_addr_t  wb_addr_o,
    output cpu_pkg::word_t      wb_data_o,
    output logic                wb_write_o,
    output cpu_pkg::word_t      read_data_o
);
    import cpu_pkg::*;

    word_t      dmem [`DMEM_WORDS];
    dmem_addr_t mem_addr;
    word_t      load_data;

    assign mem_addr    = mem_alu_result_i[$bits(dmem_addr_t)+1:2];  // byte addr to word
    assign load_data   = dmem[mem_addr];
    assign read_data_o = dmem[read_addr_i];

    // sw lands on the same edge that loads MEM/WB
    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
            wb_write_o <= 1'b0;
        end else begin
            if (mem_mem_write_i) begin
                dmem[mem_addr] <= mem_store_data_i;
            end
            wb_write_o <= mem_reg_write_i;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_addr_o <= mem_rd_addr_i;
        wb_data_o <= mem_mem_read_i ? load_data : mem_alu_result_i;
    end

endmodule

/* rtl/register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic               clk_i,
    input  logic               reset,
    input  cpu_pkg::reg_addr_t rs1_addr_i,
    input  cpu_pkg::reg_addr_t rs2_addr_i,
    input  cpu_pkg::reg_addr_t wb_addr_i,
    input  cpu_pkg::reg_addr_t read_addr_i,
    input  cpu_pkg::word_t     wb_data_i,
    input  logic               wb_write_i,
    output cpu_pkg::word_t     rs1_data_o,
    output cpu_pkg::word_t     rs2_data_o,
    output cpu_pkg::word_t     read_data_o
);
    import cpu_pkg::*;

    word_t regs [32];

    // x0 is never written, so it stays at its reset value
    always_ff @(posedge clk_i or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_write_i && wb_addr_i != '0) begin
            regs[wb_addr_i] <= wb_data_i;
        end
    end

    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (wb_write_i && wb_addr_i == addr) begin
            return wb_data_i;  // same-cycle write passes through
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data_o  = read_port(rs1_addr_i);
        rs2_data_o  = read_port(rs2_addr_i);
        read_data_o = regs[read_addr_i];  // external readout
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# builds the cpu testbench with verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module cpu_tb -f verilog.f -o cpu_sim \
    && ./obj_dir/cpu_sim | tee /dev/stderr | grep -qx "Simulation finished: PASS" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

/* verif/cpu_assertions.sv */
`timescale 1ns/1ps

module cpu_assertions (
    input logic               clk_i,
    input logic               reset,
    input logic               run_i,
    input cpu_pkg::reg_addr_t read_addr_i,
    input cpu_pkg::word_t     reg_read_data_i,
    input logic               mem_read_i,
    input logic               mem_write_i
);
    int failures = 0;  // failed assertions so far

    // run only drops through the async reset, which is still high at that edge
    run_held: assert property (@(posedge clk_i) $fell(run_i) |-> reset)
        else begin
            failures++;
            $error("run level fell while reset was low");
        end

    // x0 seen through the readout port, which has no zero override
    x0_zero: assert property (@(posedge clk_i) disable iff (reset)
        read_addr_i == '0 |-> reg_read_data_i == '0)
        else begin
            failures++;
            $error("register 0 read nonzero on the readout port");
        end

    mem_rw_exclusive: assert property (@(posedge clk_i) disable iff (reset)
        !(mem_read_i && mem_write_i))
        else begin
            failures++;
            $error("memory read and write high in the same cycle");
        end

endmodule

bind cpu_top cpu_assertions assertions_i (
    .clk_i, .reset, .run_i(run),
    .read_addr_i(address_i), .reg_read_data_i(reg_read_data),
    .mem_read_i(mem_mem_read), .mem_write_i(mem_mem_write)
);

/* verif/cpu_cases.txt */
# case <name> <word count> <check count>, then the instruction words in hex
# then per check: r (register) or m (data word), index, expected word in hex
# addi chain, then add sub and or with no forwarding needed
case alu_imm 9 6
12300093 45600113 00000000 00000000 00000000 002081b3 40110233 0020f2b3 0020e333
r 1 00000123 r 2 00000456 r 3 00000579 r 4 00000333 r 5 00000002 r 6 00000577
# dependent operands at distances 1, 2 and 3
case forwarding 6 6
00500093 00708113 002081b3 40118233 003202b3 40328333
r 1 00000005 r 2 0000000c r 3 00000011 r 4 0000000c r 5 0000001d r 6 0000000c
# sw then lw with one instruction before the use of a load
case memory 8 6
2a500093 01000113 00112223 00202423 00412183 00100213 003182b3 00802303
r 3 000002a5 r 4 00000001 r 5 0000054a r 6 00000010 m 5 000002a5 m 2 00000010
# writes to x0 and a short program ending in no-ops
case loader 4 6
05500013 03c00393 00738033 00700433
r 0 00000000 r 7 0000003c r 8 0000003c r 9 00000000 r 31 00000000 m 0 00000000
# a word with distinct bytes in a register and in data memory
case readout 10 3
6b500093 001080b3 001080b3 001080b3 001080b3 001080b3 001080b3 12308093 40100133 00202623
r 1 0001ae63 r 2 fffe519d m 3 fffe519d

/* verif/cpu_tb.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_tb;
    import cpu_pkg::*;

    localparam string CASES_FILE = "verif/cpu_cases.txt";

    logic       clk;
    logic       reset;
    byte_t      instr;
    logic       data_or_reg;
    reg_addr_t  address;
    logic [1:0] byte_sel;
    byte_t      value;

    // all cases, programs and checks stored back to back
    string case_name [$];
    int    case_len [$];
    int    case_checks [$];
    word_t prog_words [$];
    bit    check_is_reg [$];
    int    check_index [$];
    word_t check_value [$];

    int seed = 44647;
    int watchdog_cycles = 0;  // set once the cases are known

    tb_clock clock_gen_i (.clk_o(clk));

    cpu_top dut_i (
        .clk_i(clk), .reset, .instr_i(instr), .data_or_reg_i(data_or_reg),
        .address_i(address), .byte_sel_i(byte_sel), .value_o(value)
    );

    task automatic end_with_failure();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first failure");
    endtask

    function automatic bit has_end_byte(input word_t w);
        for (int b = 0; b < 4; b++) begin
            if (w[8*b +: 8] == `LOAD_END_BYTE) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic read_cases();
        int    fd;
        int    n;
        int    len;
        int    checks;
        int    idx;
        string tok;
        string name;
        string kind;
        string rest;
        word_t w;
        fd = $fopen(CASES_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the cases file %s", CASES_FILE);
            end_with_failure();
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                n = $fgets(rest, fd);  // skip comment line
            end else if (tok != "case") begin
                $display("unexpected token %s in the cases file", tok);
                end_with_failure();
            end else begin
                n = $fscanf(fd, "%s %d %d", name, len, checks);
                case_name.push_back(name);
                case_len.push_back(len);
                case_checks.push_back(checks);
                for (int i = 0; i < len; i++) begin
                    n = $fscanf(fd, "%h", w);
                    if (n != 1 || has_end_byte(w)) begin
                        $display("case %s has a bad instruction word", name);
                        end_with_failure();
                    end
                    prog_words.push_back(w);
                end
                for (int i = 0; i < checks; i++) begin
                    n = $fscanf(fd, "%s %d %h", kind, idx, w);
                    if (n != 3 || (kind != "r" && kind != "m")) begin
                        $display("case %s has a malformed check entry", name);
                        end_with_failure();
                    end
                    check_is_reg.push_back(kind == "r");
                    check_index.push_back(idx);
                    check_value.push_back(w);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        instr <= '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
    endtask

    // idle bytes, start byte, the whole imem low byte first, end byte
    task automatic load_program(input int first, input int len);
        int    pad;
        byte_t idle;
        word_t w;
        pad = 1 + ({$random(seed)} % 3);
        repeat (pad) begin
            idle = byte_t'($random(seed));
            if (idle == `LOAD_START_BYTE) begin
                idle = 8'h00;
            end
            instr <= idle;
            @(posedge clk);
        end
        instr <= `LOAD_START_BYTE;
        @(posedge clk);
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            if (i < len) begin
                w = prog_words[first + i];
            end else begin
                w = '0;  // no-op tail
            end
            for (int b = 0; b < 4; b++) begin
                instr <= w[8*b +: 8];
                @(posedge clk);
            end
        end
        instr <= `LOAD_END_BYTE;
        @(posedge clk);
        instr <= '0;
    endtask

    task automatic check_word(input string name, input int k);
        word_t exp_word;
        byte_t exp_byte;
        exp_word = check_value[k];
        for (int b = 0; b < 4; b++) begin
            @(posedge clk);
            data_or_reg <= check_is_reg[k];
            address     <= reg_addr_t'(check_index[k]);
            byte_sel    <= 2'(b);
            @(negedge clk);  // value is combinational, stable here
            exp_byte = exp_word[8*b +: 8];
            assert (value == exp_byte) else begin
                $display("error: case %s %s%0d byte %0d expected %02h actual %02h", name,
                         check_is_reg[k] ? "x" : "mem", check_index[k], b, exp_byte, value);
                end_with_failure();
            end
        end
    endtask

    initial begin : watchdog
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired before all cases finished");
        end_with_failure();
    end

    always @(posedge clk) begin
        if (dut_i.assertions_i.failures != 0) begin
            $display("a bound assertion failed at %0t", $time);
            end_with_failure();
        end
    end

    initial begin : main
        int first_word;
        int first_check;
        reset       = 1'b1;
        instr       = '0;
        data_or_reg = 1'b0;
        address     = '0;
        byte_sel    = '0;
        first_word  = 0;
        first_check = 0;
        read_cases();
        if (case_name.size() == 0) begin
            $display("no cases found in %s", CASES_FILE);
            end_with_failure();
        end
        for (int c = 0; c < case_name.size(); c++) begin
            watchdog_cycles += 4 * `IMEM_WORDS + case_len[c] + 4 * case_checks[c] + 40;
        end
        for (int c = 0; c < case_name.size(); c++) begin
            apply_reset();
            load_program(first_word, case_len[c]);
            repeat (case_len[c] + 8) @(posedge clk);  // drains the pipeline
            for (int k = 0; k < case_checks[c]; k++) begin
                check_word(case_name[c], first_check + k);
            end
            first_word  += case_len[c];
            first_check += case_checks[c];
        end
        if (dut_i.assertions_i.failures == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("a bound assertion failed during the run");
            end_with_failure();
        end
    end

endmodule

/* verif/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;  // 40 ns period
    end

endmodule

/* verilog.f */
+incdir+include
rtl/cpu_pkg.sv
rtl/instr_fetch.sv
rtl/decode_stage.sv
rtl/register_file.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/cpu_top.sv
verif/tb_clock.sv
verif/cpu_assertions.sv
verif/cpu_tb.sv
